//--- Makefile
# Verilator build and run for the RV32I front end

VERILATOR ?= verilator
TOP       ?= rv_frontend_tb
FILELIST  ?= rv_frontend.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/rv_frontend_props.sv
// Bound assertions for rv_frontend; Wishbone handshake rules and the redirect strobe
`timescale 1ns/10ps
`default_nettype none

module rv_frontend_props #(
  parameter int unsigned XLEN = 32
) (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            wb_cyc_o,
  input logic            wb_stb_o,
  input logic [XLEN-1:0] wb_adr_o,
  input logic            wb_ack_i,
  input logic            wb_err_i,
  input logic            pd_bubble_o,
  input logic            pd_redirect
);

  //////////////////////////////////////////////////
  // Wishbone
  //////////////////////////////////////////////////

  // Cycle closes right after the slave answers
  a_cyc_end : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_cyc_o && (wb_ack_i || wb_err_i)) |=> (!wb_cyc_o && !wb_stb_o))
    else $error("cycle still open after ack");

  // Strobe, cycle and address held while waiting for the slave
  a_adr_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_stb_o && !wb_ack_i && !wb_err_i) |=> (wb_stb_o && wb_cyc_o && $stable(wb_adr_o)))
    else $error("cycle or address dropped before ack");

  //////////////////////////////////////////////////
  // Pre-decoder
  //////////////////////////////////////////////////

  a_redirect_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pd_redirect |=> !pd_redirect)
    else $error("redirect high two cycles in a row");

  a_reset_bubble : assert property (@(posedge clk_i)
    $rose(rst_ni) |-> pd_bubble_o)
    else $error("no bubble right after reset");

endmodule

bind rv_frontend rv_frontend_props #(.XLEN(XLEN)) u_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .wb_cyc_o    (wb_cyc_o),
  .wb_stb_o    (wb_stb_o),
  .wb_adr_o    (wb_adr_o),
  .wb_ack_i    (wb_ack_i),
  .wb_err_i    (wb_err_i),
  .pd_bubble_o (pd_bubble_o),
  .pd_redirect (pd_redirect)
);

`default_nettype wire

//--- bench/rv_frontend_tb.sv
// Testbench for the RV32I front end; Wishbone memory model, event table and PC reference model
`timescale 1ns/10ps
`default_nettype none

module rv_frontend_tb;

  localparam int          XLEN     = 32;
  localparam logic [31:0] LOOP_PC  = 32'h260;
  localparam int          N_PROG   = 19;
  localparam int          N_EV     = 5;
  localparam int          N_FLUSH  = 3;
  localparam int          CSR_HOLD = 10;
  // Watchdog budget, program runs about three times
  localparam int          TIMEOUT_CYC = 40 * 3 * N_PROG + 120;

  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] insn;
    logic        err;
  } prog_t;

  typedef struct packed {
    int          cyc;
    int          stall;
    logic        flush;
    logic [31:0] pc;
    logic        kill;
  } ev_t;

  // Program image
  prog_t prog [N_PROG] = '{
    '{32'h200, 32'h00500093, 1'b0}, '{32'h204, 32'h00308113, 1'b0},
    '{32'h208, 32'h002081B3, 1'b0}, '{32'h20C, 32'h34009073, 1'b0},
    '{32'h210, 32'h34002273, 1'b0}, '{32'h214, 32'h34111073, 1'b0},
    '{32'h218, 32'h30200073, 1'b0}, '{32'h21C, 32'h00000863, 1'b0},
    '{32'h220, 32'h0100006F, 1'b0}, '{32'h230, 32'h00100293, 1'b0},
    '{32'h234, 32'h00000013, 1'b1}, '{32'h238, 32'h0080006F, 1'b0},
    '{32'h240, 32'h00C0006F, 1'b0}, '{32'h244, 32'h00128293, 1'b0},
    '{32'h248, 32'h0100006F, 1'b0}, '{32'h24C, 32'hFE504CE3, 1'b0},
    '{32'h258, 32'h000002B3, 1'b0}, '{32'h25C, 32'h00700313, 1'b0},
    '{32'h260, 32'h0000006F, 1'b0}
  };

  // Cycle, stall length, flush, flush target, kill
  // Kill inside a stall drops the held word, nothing is popped
  ev_t events [N_EV] = '{
    '{12,  3, 1'b0, 32'h000, 1'b0},
    '{40,  0, 1'b1, 32'h230, 1'b0},
    '{55,  2, 1'b0, 32'h000, 1'b1},
    '{70,  0, 1'b1, 32'h200, 1'b1},
    '{120, 0, 1'b1, 32'h200, 1'b0}
  };

  logic              clk_i = 1'b0;
  logic              rst_ni = 1'b0;
  logic              id_stall_i = 1'b0;
  logic              kill_i = 1'b0;
  logic              flush_i = 1'b0;
  logic [XLEN-1:0]   flush_pc_i = '0;
  logic [31:0]       wb_dat_i = '0;
  logic              wb_ack_i = 1'b0;
  logic              wb_err_i = 1'b0;
  logic              wb_cyc_o, wb_stb_o, wb_we_o;
  logic [XLEN-1:0]   wb_adr_o;
  logic [3:0]        wb_sel_o;
  logic              pd_stall_o, pd_bubble_o, pd_exc_o, pd_pred_taken_o;
  logic [XLEN-1:0]   pd_pc_o;
  logic [31:0]       pd_insn_o;
  logic [4:0]        pd_rs1_o, pd_rs2_o;
  logic [11:0]       pd_csr_reg_o;

  logic [31:0] mem_insn [1024];
  logic        mem_err  [1024];

  // Memory model state, sampled at negedge
  logic        req_s = 1'b0;
  logic [31:0] adr_s = '0;
  logic        stb_prev = 1'b0;
  int          dly = -1;

  // Reference model and checker state
  logic [31:0] exp_pc = 32'h200;
  logic [31:0] last_pc, last_insn;
  logic        last_bub, last_exc, last_pred, last_csr;
  logic [4:0]  head_rs1, head_rs2;
  logic [11:0] head_csr;
  logic        stall_seen = 1'b0;
  logic        flush_seen = 1'b0;
  logic        running = 1'b0;
  logic        done = 1'b0;
  int          hazard_cnt = 0;
  int          exc_cnt = 0;
  int          flush_cnt = 0;
  int          trig_cnt = 0;
  int          trig_used = 0;
  int          err_cnt = 0;
  int          cycle = 0;
  int          ev_idx = 0;
  int          stall_left = 0;

  rv_frontend #(.XLEN(XLEN), .PC_INIT(32'h200)) i_dut (.*);

  initial begin
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      err_cnt++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  function automatic logic csr_op(logic [31:0] w);
    return (w[6:0] == rv_fe_pkg::OPC_SYSTEM) && (w[14:12] != 3'd0) && (w[14:12] != 3'd4);
  endfunction

  function automatic logic xret_op(logic [31:0] w);
    return (w == rv_fe_pkg::PRIV_MRET) || (w == rv_fe_pkg::PRIV_SRET) ||
           (w == rv_fe_pkg::PRIV_URET);
  endfunction

  // Fill word is an ADDI with the address as immediate
  task automatic load_memory();
    for (int i = 0; i < 1024; i++) begin
      mem_insn[i] = {i[9:0], 2'b00, 5'd0, 3'd0, 5'd1, 7'h13};
      mem_err[i]  = 1'b0;
    end
    for (int k = 0; k < N_PROG; k++) begin
      mem_insn[prog[k].adr[11:2]] = prog[k].insn;
      mem_err[prog[k].adr[11:2]]  = prog[k].err;
    end
  endtask

  // One fresh pd output against the reference stream
  task automatic check_new_output();
    logic [31:0] w;
    logic        err;
    logic        taken;
    logic [31:0] nxt;
    w     = mem_insn[exp_pc[11:2]];
    err   = mem_err[exp_pc[11:2]];
    taken = !err && ((w[6:0] == rv_fe_pkg::OPC_JAL) ||
                     ((w[6:0] == rv_fe_pkg::OPC_BRANCH) && w[31]));
    check("pd_pc_o", pd_pc_o, exp_pc);
    check("pd_insn_o", pd_insn_o, w);
    check("pd_exc_o", 32'(pd_exc_o), 32'(err));
    check("pd_pred_taken_o", 32'(pd_pred_taken_o), 32'(taken));
    check("pd_rs1_o", 32'(head_rs1), 32'(w[19:15]));
    check("pd_rs2_o", 32'(head_rs2), 32'(w[24:20]));
    check("pd_csr_reg_o", 32'(head_csr), 32'(w[31:20]));
    // CSR read or xRET never directly behind a CSR op
    if (csr_op(w) || xret_op(w)) check("CSR hazard gap", 32'(last_csr), 32'd0);
    // Next PC rules
    if (err) nxt = exp_pc + 32'd4;
    else if (w[6:0] == rv_fe_pkg::OPC_JAL)
      nxt = exp_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    else if ((w[6:0] == rv_fe_pkg::OPC_BRANCH) && w[31])
      nxt = exp_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    else nxt = exp_pc + 32'd4;
    if (err) exc_cnt++;
    if (exp_pc == LOOP_PC && flush_cnt == N_FLUSH) done = 1'b1;
    exp_pc = nxt;
  endtask

  //////////////////////////////////////////////////
  // Wishbone memory, 0 to 2 wait cycles
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    req_s = rst_ni && wb_cyc_o && wb_stb_o;
    adr_s = wb_adr_o;
  end

  always @(posedge clk_i) begin
    wb_ack_i <= 1'b0;
    wb_err_i <= 1'b0;
    if (req_s && !wb_ack_i && !wb_err_i) begin
      if (dly < 0) dly = int'($urandom % 3);
      if (dly == 0) begin
        wb_dat_i <= mem_insn[adr_s[11:2]];
        if (mem_err[adr_s[11:2]]) wb_err_i <= 1'b1;
        else wb_ack_i <= 1'b1;
        dly = -1;
      end else begin
        dly = dly - 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checker, outputs sampled at negedge
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (running) begin
      if (pd_stall_o && !id_stall_i) hazard_cnt++;
      // Read-only master with all byte lanes
      if (wb_cyc_o) begin
        check("wb_we_o", 32'(wb_we_o), 32'd0);
        check("wb_sel_o", 32'(wb_sel_o), 32'hf);
      end
      // Flush or kill at the last edge leaves a bubble
      if (flush_seen) check("pd_bubble_o after flush or kill", 32'(pd_bubble_o), 32'd1);
      if (!stall_seen && !pd_bubble_o) begin
        check_new_output();
      end else if (stall_seen && !flush_seen) begin
        // Held stage registers
        check("held pd_pc_o", pd_pc_o, last_pc);
        check("held pd_insn_o", pd_insn_o, last_insn);
        check("held pd_bubble_o", 32'(pd_bubble_o), 32'(last_bub));
        check("held pd_exc_o", 32'(pd_exc_o), 32'(last_exc));
        check("held pd_pred_taken_o", 32'(pd_pred_taken_o), 32'(last_pred));
      end
      last_pc    = pd_pc_o;
      last_insn  = pd_insn_o;
      last_bub   = pd_bubble_o;
      last_exc   = pd_exc_o;
      last_pred  = pd_pred_taken_o;
      last_csr   = !pd_bubble_o && csr_op(pd_insn_o);
      head_rs1   = pd_rs1_o;
      head_rs2   = pd_rs2_o;
      head_csr   = pd_csr_reg_o;
      stall_seen = id_stall_i;
      flush_seen = flush_i || kill_i;
      if (flush_i) begin
        exp_pc = flush_pc_i;
        flush_cnt++;
      end
      // Fetch of a CSR write, hold decode so the pair queues up
      if (wb_stb_o && !stb_prev && (wb_adr_o == 32'h20C || wb_adr_o == 32'h214)) trig_cnt++;
      stb_prev = wb_stb_o;
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  task automatic drive_cycle();
    flush_i <= 1'b0;
    kill_i  <= 1'b0;
    if (ev_idx < N_EV && cycle == events[ev_idx].cyc) begin
      if (events[ev_idx].stall > stall_left) stall_left = events[ev_idx].stall;
      if (events[ev_idx].flush) begin
        flush_i    <= 1'b1;
        flush_pc_i <= events[ev_idx].pc;
      end
      kill_i <= events[ev_idx].kill;
      ev_idx++;
    end
    if (trig_cnt != trig_used) begin
      trig_used = trig_cnt;
      if (CSR_HOLD > stall_left) stall_left = CSR_HOLD;
    end
    id_stall_i <= (stall_left > 0);
    if (stall_left > 0) stall_left--;
  endtask

  initial begin
    void'($urandom(29));
    load_memory();
    repeat (3) @(posedge clk_i);
    rst_ni  <= 1'b1;
    running = 1'b1;
    @(negedge clk_i);
    check("pd_bubble_o after reset", 32'(pd_bubble_o), 32'd1);
    check("pd_exc_o after reset", 32'(pd_exc_o), 32'd0);
    check("pd_pc_o after reset", pd_pc_o, 32'h200);
    check("wb_cyc_o after reset", 32'(wb_cyc_o), 32'd0);
    check("wb_stb_o after reset", 32'(wb_stb_o), 32'd0);
    while (!done) begin
      @(posedge clk_i);
      drive_cycle();
      cycle++;
    end
    check("CSR hazard stalls", 32'(hazard_cnt >= 2), 32'd1);
    check("bus error words seen", 32'(exc_cnt > 0), 32'd1);
    if (err_cnt == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("Some tests failed");
      $fatal(1);
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYC * 20);
    $display("Watchdog expired, reference stream never reached its end");
    $display("Some tests failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- rv_frontend.f
verilog/rv_fe_pkg.sv
verilog/rv_fetch.sv
verilog/rv_fetch_buf.sv
verilog/rv_predecode.sv
verilog/rv_frontend.sv
bench/rv_frontend_props.sv
bench/rv_frontend_tb.sv

//--- verilog/rv_fe_pkg.sv
// Shared RV32I front-end definitions; referenced by scoped name from every RTL file and the bench
`default_nettype none

package rv_fe_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Default data and address width
  localparam int unsigned XLEN_DEF = 32;
  // Instruction word
  localparam int unsigned ILEN     = 32;
  // Register file address
  localparam int unsigned REG_AW   = 5;
  // CSR address
  localparam int unsigned CSR_AW   = 12;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // funct3 within SYSTEM
  typedef enum logic [2:0] {
    F3_PRIV   = 3'b000,
    F3_CSRRW  = 3'b001,
    F3_CSRRS  = 3'b010,
    F3_CSRRC  = 3'b011,
    F3_CSRRWI = 3'b101,
    F3_CSRRSI = 3'b110,
    F3_CSRRCI = 3'b111
  } sys_funct_e;

  // Trap returns, full words
  localparam logic [ILEN-1:0] PRIV_MRET = 32'h3020_0073;
  localparam logic [ILEN-1:0] PRIV_SRET = 32'h1020_0073;
  localparam logic [ILEN-1:0] PRIV_URET = 32'h0020_0073;

  // ADDI x0,x0,0
  localparam logic [ILEN-1:0] INSN_NOP  = 32'h0000_0013;

  // Reset fetch address
  localparam logic [XLEN_DEF-1:0] PC_INIT_DEF = 32'h0000_0200;

  //////////////////////////////////////////////////
  // Field helpers
  //////////////////////////////////////////////////

  // True for any of the six CSR access forms
  function automatic logic is_csr_f3(logic [2:0] f3);
    case (sys_funct_e'(f3))
      F3_CSRRW, F3_CSRRS, F3_CSRRC,
      F3_CSRRWI, F3_CSRRSI, F3_CSRRCI: return 1'b1;
      default:                         return 1'b0;
    endcase
  endfunction

  // B-type offset, bit 0 always zero
  function automatic logic [12:0] imm_b(logic [ILEN-1:0] insn);
    return {insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  endfunction

  // J-type offset, bit 0 always zero
  function automatic logic [20:0] imm_j(logic [ILEN-1:0] insn);
    return {insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  endfunction

endpackage

`default_nettype wire

//--- verilog/rv_fetch.sv
// Instruction fetch unit; Wishbone classic read master that feeds the fetch buffer in rv_frontend
`timescale 1ns/10ps
`default_nettype none

module rv_fetch #(
  parameter int unsigned     XLEN    = 32,
  parameter logic [XLEN-1:0] PC_INIT = 'h200
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // New PC sources, flush wins
  input  logic                       redirect_i,
  input  logic                       flush_i,
  input  logic [XLEN-1:0]            redirect_pc_i,
  input  logic [XLEN-1:0]            flush_pc_i,
  // Buffer can take one more word
  input  logic                       buf_space_i,
  // Wishbone classic master
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic                       wb_we_o,
  output logic [XLEN-1:0]            wb_adr_o,
  output logic [3:0]                 wb_sel_o,
  input  logic [31:0]                wb_dat_i,
  input  logic                       wb_ack_i,
  input  logic                       wb_err_i,
  // Toward the buffer
  output logic                       push_o,
  output logic                       err_o,
  output logic [XLEN-1:0]            pc_o,
  output logic [rv_fe_pkg::ILEN-1:0] insn_o
);

  // Word aligned, no compressed support
  localparam logic [XLEN-1:0] ADR_MASK = {XLEN{1'b1}} << 2;

  typedef enum logic {
    FS_IDLE,
    FS_BUSY
  } fetch_state_e;

  fetch_state_e    state_q;
  // Next address to fetch
  logic [XLEN-1:0] pc_q;
  // Address of the read on the bus
  logic [XLEN-1:0] adr_q;
  // Read in flight belongs to an old stream
  logic            stale_q;
  logic            new_pc;
  logic [XLEN-1:0] new_pc_val;
  logic            bus_done;
  logic            start;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  assign new_pc     = redirect_i | flush_i;
  assign new_pc_val = (flush_i ? flush_pc_i : redirect_pc_i) & ADR_MASK;

  // Ack or err ends the bus cycle
  assign bus_done = (state_q == FS_BUSY) & (wb_ack_i | wb_err_i);

  // Open a cycle only with nothing outstanding and room downstream
  assign start = (state_q == FS_IDLE) & buf_space_i & ~new_pc;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FS_IDLE;
    end else begin
      case (state_q)
        FS_IDLE: if (start) state_q <= FS_BUSY;
        FS_BUSY: if (bus_done) state_q <= FS_IDLE;
        default: state_q <= FS_IDLE;
      endcase
    end
  end

  // Redirect while busy marks the pending word for discard
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stale_q <= 1'b0;
    end else if (bus_done) begin
      stale_q <= 1'b0;
    end else if (new_pc && state_q == FS_BUSY) begin
      stale_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Addresses
  //////////////////////////////////////////////////

  // Step by one word after each accepted word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= PC_INIT & ADR_MASK;
    end else if (new_pc) begin
      pc_q <= new_pc_val;
    end else if (push_o) begin
      pc_q <= pc_q + XLEN'(4);
    end
  end

  // Held for the whole cycle, even across a redirect
  always_ff @(posedge clk_i) begin
    if (start) begin
      adr_q <= pc_q;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  assign wb_cyc_o = (state_q == FS_BUSY);
  assign wb_stb_o = (state_q == FS_BUSY);
  assign wb_we_o  = 1'b0;
  assign wb_sel_o = 4'hf;
  assign wb_adr_o = adr_q;

  // Word goes out unless stale or overtaken this very cycle
  assign push_o = bus_done & ~stale_q & ~new_pc;
  assign err_o  = wb_err_i;
  assign pc_o   = adr_q;
  assign insn_o = wb_dat_i;

endmodule

`default_nettype wire

//--- verilog/rv_fetch_buf.sv
// Small FIFO of fetched words between rv_fetch and rv_predecode; cleared on every PC change
`timescale 1ns/10ps
`default_nettype none

module rv_fetch_buf #(
  parameter int unsigned XLEN      = 32,
  parameter int unsigned BUF_DEPTH = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       push_i,
  input  logic                       pop_i,
  input  logic [XLEN-1:0]            pc_i,
  input  logic [rv_fe_pkg::ILEN-1:0] insn_i,
  input  logic                       err_i,
  output logic                       valid_o,
  output logic                       space_o,
  output logic                       err_o,
  output logic [XLEN-1:0]            pc_o,
  output logic [rv_fe_pkg::ILEN-1:0] insn_o
);

  localparam int unsigned PTR_W = $clog2(BUF_DEPTH);

  // Storage
  logic [XLEN-1:0]            pc_mem   [BUF_DEPTH];
  logic [rv_fe_pkg::ILEN-1:0] insn_mem [BUF_DEPTH];
  logic [BUF_DEPTH-1:0]       err_mem;

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W:0]   cnt_q;
  logic             do_push;
  logic             do_pop;

  assign valid_o = (cnt_q != '0);
  // Fetch opens a read only with nothing else outstanding, so one slot covers it
  assign space_o = (cnt_q < (PTR_W+1)'(BUF_DEPTH));
  assign do_pop  = pop_i & valid_o;
  assign do_push = push_i & (space_o | do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      pc_mem[wr_ptr_q]   <= pc_i;
      insn_mem[wr_ptr_q] <= insn_i;
      err_mem[wr_ptr_q]  <= err_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Head shown without a register stage
  assign pc_o   = pc_mem[rd_ptr_q];
  assign insn_o = insn_mem[rd_ptr_q];
  assign err_o  = err_mem[rd_ptr_q];

endmodule

`default_nettype wire

//--- verilog/rv_frontend.sv
// RV32I instruction front end top; fetch, buffer and pre-decoder for the decode stage
`timescale 1ns/10ps
`default_nettype none

module rv_frontend #(
  parameter int unsigned     XLEN      = rv_fe_pkg::XLEN_DEF,
  parameter logic [XLEN-1:0] PC_INIT   = rv_fe_pkg::PC_INIT_DEF,
  parameter int unsigned     BUF_DEPTH = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         id_stall_i,
  input  logic                         kill_i,
  input  logic                         flush_i,
  input  logic [XLEN-1:0]              flush_pc_i,
  // Wishbone classic master
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic                         wb_we_o,
  output logic [XLEN-1:0]              wb_adr_o,
  output logic [3:0]                   wb_sel_o,
  input  logic [31:0]                  wb_dat_i,
  input  logic                         wb_ack_i,
  input  logic                         wb_err_i,
  // Toward decode
  output logic                         pd_stall_o,
  output logic [XLEN-1:0]              pd_pc_o,
  output logic [rv_fe_pkg::ILEN-1:0]   pd_insn_o,
  output logic                         pd_bubble_o,
  output logic                         pd_exc_o,
  output logic                         pd_pred_taken_o,
  output logic [rv_fe_pkg::REG_AW-1:0] pd_rs1_o,
  output logic [rv_fe_pkg::REG_AW-1:0] pd_rs2_o,
  output logic [rv_fe_pkg::CSR_AW-1:0] pd_csr_reg_o
);

  // Fetch to buffer
  logic                       fe_push;
  logic                       fe_err;
  logic [XLEN-1:0]            fe_pc;
  logic [rv_fe_pkg::ILEN-1:0] fe_insn;
  // Buffer head
  logic                       fb_valid;
  logic                       fb_err;
  logic [XLEN-1:0]            fb_pc;
  logic [rv_fe_pkg::ILEN-1:0] fb_insn;
  logic                       buf_space;
  logic                       buf_clear;
  // Pre-decoder
  logic                       pd_pop;
  logic                       pd_redirect;
  logic [XLEN-1:0]            pd_nxt_pc;

  // Any PC change empties the buffer
  assign buf_clear = pd_redirect | flush_i;

  rv_fetch #(
    .XLEN    (XLEN),
    .PC_INIT (PC_INIT)
  ) u_fetch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (pd_redirect),
    .flush_i       (flush_i),
    .redirect_pc_i (pd_nxt_pc),
    .flush_pc_i    (flush_pc_i),
    .buf_space_i   (buf_space),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_sel_o      (wb_sel_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i),
    .wb_err_i      (wb_err_i),
    .push_o        (fe_push),
    .err_o         (fe_err),
    .pc_o          (fe_pc),
    .insn_o        (fe_insn)
  );

  rv_fetch_buf #(
    .XLEN      (XLEN),
    .BUF_DEPTH (BUF_DEPTH)
  ) u_fetch_buf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (buf_clear),
    .push_i  (fe_push),
    .pop_i   (pd_pop),
    .pc_i    (fe_pc),
    .insn_i  (fe_insn),
    .err_i   (fe_err),
    .valid_o (fb_valid),
    .space_o (buf_space),
    .err_o   (fb_err),
    .pc_o    (fb_pc),
    .insn_o  (fb_insn)
  );

  rv_predecode #(
    .XLEN    (XLEN),
    .PC_INIT (PC_INIT)
  ) u_predecode (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .id_stall_i      (id_stall_i),
    .kill_i          (kill_i),
    .flush_i         (flush_i),
    .fb_valid_i      (fb_valid),
    .fb_err_i        (fb_err),
    .fb_pc_i         (fb_pc),
    .fb_insn_i       (fb_insn),
    .pop_o           (pd_pop),
    .pd_stall_o      (pd_stall_o),
    .redirect_o      (pd_redirect),
    .nxt_pc_o        (pd_nxt_pc),
    .pd_pc_o         (pd_pc_o),
    .pd_insn_o       (pd_insn_o),
    .pd_bubble_o     (pd_bubble_o),
    .pd_exc_o        (pd_exc_o),
    .pd_pred_taken_o (pd_pred_taken_o),
    .pd_rs1_o        (pd_rs1_o),
    .pd_rs2_o        (pd_rs2_o),
    .pd_csr_reg_o    (pd_csr_reg_o)
  );

endmodule

`default_nettype wire

//--- verilog/rv_predecode.sv
// Instruction pre-decoder stage; takes the fetch buffer head and registers it for the decode stage
`timescale 1ns/10ps
`default_nettype none

module rv_predecode #(
  parameter int unsigned     XLEN    = 32,
  parameter logic [XLEN-1:0] PC_INIT = 'h200
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Later stages
  input  logic                         id_stall_i,
  input  logic                         kill_i,
  input  logic                         flush_i,
  // Buffer head
  input  logic                         fb_valid_i,
  input  logic                         fb_err_i,
  input  logic [XLEN-1:0]              fb_pc_i,
  input  logic [rv_fe_pkg::ILEN-1:0]   fb_insn_i,
  output logic                         pop_o,
  output logic                         pd_stall_o,
  // Toward fetch
  output logic                         redirect_o,
  output logic [XLEN-1:0]              nxt_pc_o,
  // Stage registers
  output logic [XLEN-1:0]              pd_pc_o,
  output logic [rv_fe_pkg::ILEN-1:0]   pd_insn_o,
  output logic                         pd_bubble_o,
  output logic                         pd_exc_o,
  output logic                         pd_pred_taken_o,
  // Register file and CSR addresses, from the head
  output logic [rv_fe_pkg::REG_AW-1:0] pd_rs1_o,
  output logic [rv_fe_pkg::REG_AW-1:0] pd_rs2_o,
  output logic [rv_fe_pkg::CSR_AW-1:0] pd_csr_reg_o
);

  localparam logic [XLEN-1:0] ADR_MASK = {XLEN{1'b1}} << 2;

  logic [rv_fe_pkg::ILEN-1:0] head_insn;
  rv_fe_pkg::opcode_e         head_opc;
  rv_fe_pkg::opcode_e         pd_opc;
  logic                       csr_rd;
  logic                       csr_wr;
  logic                       xret;
  logic [12:0]                imm_b;
  logic [20:0]                imm_j;
  logic [XLEN-1:0]            ext_imm_b;
  logic [XLEN-1:0]            ext_imm_j;
  logic                       is_jal;
  logic                       is_branch;
  logic                       branch_taken;

  // Empty buffer reads as a NOP
  assign head_insn = fb_valid_i ? fb_insn_i : rv_fe_pkg::INSN_NOP;
  assign head_opc  = rv_fe_pkg::opcode_e'(head_insn[6:0]);
  assign pd_opc    = rv_fe_pkg::opcode_e'(pd_insn_o[6:0]);

  //////////////////////////////////////////////////
  // CSR hazard
  //////////////////////////////////////////////////

  assign csr_rd = fb_valid_i & (head_opc == rv_fe_pkg::OPC_SYSTEM) &
                  rv_fe_pkg::is_csr_f3(head_insn[14:12]);

  assign xret = fb_valid_i & ((head_insn == rv_fe_pkg::PRIV_MRET) |
                              (head_insn == rv_fe_pkg::PRIV_SRET) |
                              (head_insn == rv_fe_pkg::PRIV_URET));

  // Any CSR op counts as a write here
  assign csr_wr = ~pd_bubble_o & (pd_opc == rv_fe_pkg::OPC_SYSTEM) &
                  rv_fe_pkg::is_csr_f3(pd_insn_o[14:12]);

  assign pd_stall_o = id_stall_i | ((csr_rd | xret) & csr_wr);
  assign pop_o      = fb_valid_i & ~pd_stall_o;

  assign pd_rs1_o     = head_insn[19:15];
  assign pd_rs2_o     = head_insn[24:20];
  assign pd_csr_reg_o = head_insn[31:20];

  //////////////////////////////////////////////////
  // Static prediction
  //////////////////////////////////////////////////

  assign imm_b     = rv_fe_pkg::imm_b(head_insn);
  assign imm_j     = rv_fe_pkg::imm_j(head_insn);
  assign ext_imm_b = {{(XLEN-13){imm_b[12]}}, imm_b};
  assign ext_imm_j = {{(XLEN-21){imm_j[20]}}, imm_j};

  // A bus error word carries no usable opcode
  assign is_jal    = fb_valid_i & ~fb_err_i & (head_opc == rv_fe_pkg::OPC_JAL);
  assign is_branch = fb_valid_i & ~fb_err_i & (head_opc == rv_fe_pkg::OPC_BRANCH);

  // JAL always, branches only backward
  assign branch_taken = is_jal | (is_branch & imm_b[12]);
  assign nxt_pc_o     = (fb_pc_i + (is_jal ? ext_imm_j : ext_imm_b)) & ADR_MASK;

  // Head leaves on pop, so the strobe cannot repeat
  // Killed or flushed branches steer nothing
  assign redirect_o = pop_o & branch_taken & ~flush_i & ~kill_i;

  //////////////////////////////////////////////////
  // Stage registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_pc_o   <= PC_INIT & ADR_MASK;
      pd_insn_o <= rv_fe_pkg::INSN_NOP;
    end else if (pop_o) begin
      pd_pc_o   <= fb_pc_i & ADR_MASK;
      pd_insn_o <= fb_insn_i;
    end
  end

  // Bubble on flush, kill, hazard or empty head
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_bubble_o     <= 1'b1;
      pd_exc_o        <= 1'b0;
      pd_pred_taken_o <= 1'b0;
    end else if (flush_i || kill_i) begin
      pd_bubble_o     <= 1'b1;
      pd_exc_o        <= 1'b0;
      pd_pred_taken_o <= 1'b0;
    end else if (!id_stall_i) begin
      pd_bubble_o     <= ~pop_o;
      pd_exc_o        <= pop_o & fb_err_i;
      pd_pred_taken_o <= pop_o & branch_taken;
    end
  end

endmodule

`default_nettype wire
